// File: Bender.yml
package:
  name: synth

sources:
  - include_dirs:
      - common
    files:
      - common/synth_pkg.sv
      - midi/midi_uart_rx.sv
      - midi/midi_parser.sv
      - voice/voice_alloc.sv
      - voice/voice_osc.sv
      - rtl/sigma_delta_dac.sv
      - rtl/synth_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/synth_tb.sv

// File: common/synth_pkg.sv
`include "synth_settings.svh"

package synth_pkg;

  typedef logic [7:0] midi_byte_t; // raw byte off the wire
  typedef logic [6:0] note_t; // midi note number
  typedef logic [6:0] velocity_t; // midi velocity
  typedef logic [1:0] voice_idx_t; // slot index
  typedef logic [`PHASE_W-1:0] phase_t; // oscillator phase
  typedef logic signed [`SAMPLE_W-1:0] sample_t; // one voice output
  typedef logic signed [`MIX_W-1:0] mix_t; // summed voices

  typedef enum logic {NOTE_ON, NOTE_OFF} note_cmd_e;

  typedef enum logic [1:0] {WAIT_STATUS, WAIT_NOTE, WAIT_VEL} parse_state_e;

  // increments for notes 120..131 at 25 MHz
  // lower octaves shift right by one per octave
  localparam phase_t base_inc [12] = '{
    24'd5618, 24'd5952, 24'd6306, 24'd6681,
    24'd7079, 24'd7500, 24'd7946, 24'd8418,
    24'd8919, 24'd9449, 24'd10011, 24'd10606
  };

endpackage

// File: common/synth_settings.svh
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

////////////////////
// clocking and serial line

`define CLKS_PER_BIT 800 // 25 MHz / 31250 baud

////////////////////
// voices and datapath widths

`define NUM_VOICES 4 // polyphony
`define PHASE_W 24 // phase accumulator bits
`define SINE_ADDR_W 8 // sine table is 2^8 entries
`define SAMPLE_W 16 // one voice sample
`define MIX_W 18 // four voices add without overflow

`endif

// File: midi/midi_parser.sv
`timescale 1ns/1ps

module midi_parser import synth_pkg::*; (
  input logic Clk,
  input logic reset,
  input midi_byte_t rx_byte,
  input logic rx_valid,
  output logic ev_valid,
  output note_cmd_e ev_cmd,
  output note_t ev_note,
  input logic ev_ready
);

  parse_state_e state; // WAIT_STATUS means no running status
  note_cmd_e run_cmd; // command of the running status
  note_t note_r; // first data byte of the pair
  velocity_t vel;
  logic byte_take; // byte accepted this cycle
  logic is_status;
  logic is_system; // 0xF0 and up
  logic is_note; // 0x8n or 0x9n

  assign vel = rx_byte[6:0];
  assign byte_take = rx_valid && !ev_valid; // drop while an event waits
  assign is_status = rx_byte[7];
  assign is_system = (rx_byte[7:4] == 4'hF);
  assign is_note = (rx_byte[7:5] == 3'b100);

  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= WAIT_STATUS;
      ev_valid <= 1'b0;
    end else begin
      if (ev_valid && ev_ready) begin
        ev_valid <= 1'b0; // handed to the allocator
      end
      if (byte_take) begin
        if (is_status) begin
          if (!is_system) begin
            state <= is_note ? WAIT_NOTE : WAIT_STATUS; // realtime leaves state alone
          end
        end else begin
          case (state)
            WAIT_NOTE: state <= WAIT_VEL;
            WAIT_VEL: begin
              state <= WAIT_NOTE; // stay ready for running status
              ev_valid <= 1'b1;
            end
            default: state <= WAIT_STATUS; // stray data byte
          endcase
        end
      end
    end
  end

  ////////////////////
  // message payload

  always_ff @(posedge Clk) begin
    if (byte_take && is_status && is_note) begin
      run_cmd <= rx_byte[4] ? NOTE_ON : NOTE_OFF; // any channel
    end
    if (byte_take && !is_status && state == WAIT_NOTE) begin
      note_r <= rx_byte[6:0];
    end
    if (byte_take && !is_status && state == WAIT_VEL) begin
      ev_note <= note_r;
      ev_cmd <= (run_cmd == NOTE_ON && vel != '0) ? NOTE_ON : NOTE_OFF; // vel 0 is off
    end
  end

endmodule

// File: midi/midi_uart_rx.sv
`timescale 1ns/1ps
`include "synth_settings.svh"

module midi_uart_rx import synth_pkg::*; (
  input logic Clk,
  input logic reset,
  input logic midi_in,
  output midi_byte_t rx_byte,
  output logic rx_valid
);

  localparam int BAUD_W = $clog2(`CLKS_PER_BIT);
  localparam logic [BAUD_W-1:0] FULL_BIT = BAUD_W'(`CLKS_PER_BIT - 1);
  localparam logic [BAUD_W-1:0] HALF_BIT = BAUD_W'(`CLKS_PER_BIT / 2 - 1);

  logic [1:0] sync; // sync[1] is the clean line
  logic line_d; // previous clean sample for edge detect
  logic busy; // frame in progress
  logic [BAUD_W-1:0] baud_cnt; // cycles left to next sample point
  logic [3:0] bit_cnt; // 0 start, 1..8 data, 9 stop
  logic sample_now; // mid-bit strobe
  logic data_bit; // strobe falls on a data bit
  midi_byte_t shift; // lsb first shifter

  assign sample_now = busy && (baud_cnt == '0);
  assign data_bit = (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8);
  assign rx_byte = shift;

  ////////////////////
  // line sync and bit timing

  always_ff @(posedge Clk) begin
    if (reset) begin
      sync <= 2'b11; // idle line is high
      line_d <= 1'b1;
      busy <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      sync <= {sync[0], midi_in};
      line_d <= sync[1];
      rx_valid <= 1'b0; // single cycle pulse
      if (!busy) begin
        if (line_d && !sync[1]) begin // falling edge opens a frame
          busy <= 1'b1;
          baud_cnt <= HALF_BIT; // land in the middle of the start bit
          bit_cnt <= '0;
        end
      end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= FULL_BIT;
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 4'd0 && sync[1]) begin
          busy <= 1'b0; // glitch and not a real start bit
        end
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;
          rx_valid <= sync[1]; // framing error gives no pulse
        end
      end
    end
  end

  ////////////////////
  // data shifter

  always_ff @(posedge Clk) begin
    if (sample_now && data_bit) begin
      shift <= {sync[1], shift[7:1]}; // lsb arrives first
    end
  end

endmodule

// File: rtl/sigma_delta_dac.sv
`timescale 1ns/1ps
`include "synth_settings.svh"

module sigma_delta_dac import synth_pkg::*; (
  input logic Clk,
  input logic reset,
  input mix_t mix_sample,
  input logic mix_valid,
  output logic pdm_out
);

  mix_t held; // last mix from the oscillator
  logic [`MIX_W-1:0] acc; // error accumulator
  logic [`MIX_W-1:0] level; // held mix plus half scale
  logic [`MIX_W:0] sum;

  assign level = {~held[`MIX_W-1], held[`MIX_W-2:0]}; // msb flip adds the offset
  assign sum = {1'b0, acc} + {1'b0, level};

  always_ff @(posedge Clk) begin
    if (reset) begin
      held <= '0;
      acc <= '0;
      pdm_out <= 1'b0;
    end else begin
      if (mix_valid) begin
        held <= mix_sample;
      end
      acc <= sum[`MIX_W-1:0];
      pdm_out <= sum[`MIX_W]; // carry is the pulse density
    end
  end

endmodule

// File: rtl/synth_top.sv
`timescale 1ns/1ps
`include "synth_settings.svh"

module synth_top import synth_pkg::*; (
  input logic Clk,
  input logic reset,
  input logic midi_in,
  output logic pdm_out,
  output logic [`NUM_VOICES-1:0] voice_active,
  output mix_t mix_sample,
  output logic mix_valid
);

  midi_byte_t rx_byte;
  logic rx_valid;
  logic ev_valid; // parser to allocator handshake
  logic ev_ready;
  note_cmd_e ev_cmd;
  note_t ev_note;
  note_t voice_note [`NUM_VOICES]; // slot table to oscillators

  midi_uart_rx u_rx (
    .Clk(Clk),
    .reset(reset),
    .midi_in(midi_in),
    .rx_byte(rx_byte),
    .rx_valid(rx_valid)
  );

  midi_parser u_parser (
    .Clk(Clk),
    .reset(reset),
    .rx_byte(rx_byte),
    .rx_valid(rx_valid),
    .ev_valid(ev_valid),
    .ev_cmd(ev_cmd),
    .ev_note(ev_note),
    .ev_ready(ev_ready)
  );

  voice_alloc u_alloc (
    .Clk(Clk),
    .reset(reset),
    .ev_valid(ev_valid),
    .ev_cmd(ev_cmd),
    .ev_note(ev_note),
    .ev_ready(ev_ready),
    .voice_active(voice_active),
    .voice_note(voice_note)
  );

  voice_osc u_osc (
    .Clk(Clk),
    .reset(reset),
    .voice_active(voice_active),
    .voice_note(voice_note),
    .mix_sample(mix_sample),
    .mix_valid(mix_valid)
  );

  sigma_delta_dac u_dac (
    .Clk(Clk),
    .reset(reset),
    .mix_sample(mix_sample),
    .mix_valid(mix_valid),
    .pdm_out(pdm_out)
  );

endmodule

// File: verif/synth_tb.sv
`timescale 1ns/1ps
`include "synth_settings.svh"

module synth_tb import synth_pkg::*; ();

  localparam int NV = `NUM_VOICES;
  localparam int MAX_CYCLES = 1_000_000; // ~80 bytes of 8000 cycles plus checks and margin
  localparam logic [`MIX_W-1:0] HALF_SCALE = 1 << (`MIX_W - 1);

  logic Clk;
  logic reset;
  logic midi_in;
  logic pdm_out;
  logic [`NUM_VOICES-1:0] voice_active;
  mix_t mix_sample;
  logic mix_valid;

  logic [31:0] rng_state; // xorshift state
  logic [`NUM_VOICES-1:0] model_active; // reference slot table
  note_t model_note [`NUM_VOICES];
  int cycles;
  int nonzero_mix; // frames with sound while voices play
  mix_t m_held; // modulator model registers
  logic [`MIX_W-1:0] m_acc;
  logic exp_pdm;
  logic rst_q; // reset as the dut saw it
  logic mv_q;
  mix_t ms_q;
  logic cmp_on; // starts one cycle after the first mix_valid

  synth_top dut0 (
    .Clk(Clk),
    .reset(reset),
    .midi_in(midi_in),
    .pdm_out(pdm_out),
    .voice_active(voice_active),
    .mix_sample(mix_sample),
    .mix_valid(mix_valid)
  );

  always #20 Clk = ~Clk; // 40 ns period

  ////////////////////
  // helpers

  task automatic stop_on_error(input string why);
    $display("error: %s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = next_rand();
    return r[16];
  endfunction

  function automatic logic [3:0] rand_chan();
    return 4'(next_rand() % 16);
  endfunction

  function automatic velocity_t rand_vel();
    return velocity_t'(1 + next_rand() % 127); // never zero
  endfunction

  function automatic logic is_held(input note_t n);
    for (int i = 0; i < NV; i++) begin
      if (model_active[i] && model_note[i] == n) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic note_t fresh_note();
    note_t n;
    n = note_t'(next_rand() % 128);
    while (is_held(n)) begin
      n = note_t'(next_rand() % 128);
    end
    return n;
  endfunction

  // same note first, then lowest free slot for note on, else dropped
  function automatic void apply_event(input note_cmd_e cmd, input note_t note);
    int slot;
    slot = -1;
    for (int i = 0; i < NV; i++) begin
      if (slot < 0 && model_active[i] && model_note[i] == note) slot = i;
    end
    if (slot >= 0) begin
      if (cmd == NOTE_OFF) model_active[slot] = 1'b0;
    end else if (cmd == NOTE_ON) begin
      for (int i = 0; i < NV; i++) begin
        if (slot < 0 && !model_active[i]) slot = i;
      end
      if (slot >= 0) begin
        model_active[slot] = 1'b1;
        model_note[slot] = note;
      end
    end
  endfunction

  ////////////////////
  // midi stimulus

  task automatic send_byte(input midi_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0}; // stop, data lsb first, start
    for (int i = 0; i < 10; i++) begin
      midi_in <= frame[i];
      repeat (`CLKS_PER_BIT) @(posedge Clk);
    end
  endtask

  task automatic send_pair(input note_t note, input velocity_t vel, input logic on_status,
                           input logic with_rt);
    if (with_rt && coin()) send_byte(8'hF8); // timing clock between pairs
    send_byte({1'b0, note});
    if (with_rt && coin()) send_byte(8'hF8); // realtime inside a pair
    send_byte({1'b0, vel});
    apply_event((on_status && vel != '0) ? NOTE_ON : NOTE_OFF, note);
  endtask

  task automatic send_msg(input midi_byte_t status, input note_t note, input velocity_t vel);
    send_byte(status);
    send_pair(note, vel, status[4], 1'b0);
  endtask

  task automatic send_off(input note_t note);
    if (coin()) begin
      send_msg({4'h8, rand_chan()}, note, velocity_t'(next_rand() % 128));
    end else begin
      send_msg({4'h9, rand_chan()}, note, '0); // note on, zero velocity
    end
  endtask

  task automatic check_voices(input string what);
    repeat (`CLKS_PER_BIT) @(posedge Clk); // one bit period after the last byte
    @(negedge Clk);
    assert (voice_active == model_active) else begin
      $display("FAIL t=%0t voice_active got %b expected %b (%s)", $time, voice_active,
               model_active, what);
      stop_on_error("voice slots differ from the model");
    end
    @(posedge Clk);
  endtask

  task automatic release_all(input logic running);
    logic [`NUM_VOICES-1:0] snap;
    note_t notes [`NUM_VOICES];
    snap = model_active;
    notes = model_note;
    if (running) send_byte({4'h8, rand_chan()});
    for (int i = 0; i < NV; i++) begin
      if (snap[i] && running) begin
        send_pair(notes[i], rand_vel(), 1'b0, 1'b1);
        check_voices("running status release");
      end else if (snap[i]) begin
        send_off(notes[i]);
        check_voices("release");
      end
    end
  endtask

  task automatic check_silence();
    int ones;
    ones = 0;
    repeat (16) @(posedge Clk); // drain the pipeline into the dac
    for (int i = 0; i < 4096; i++) begin
      @(negedge Clk);
      ones += pdm_out;
      if (mix_valid) begin
        assert (mix_sample == '0) else begin
          $display("FAIL t=%0t mix_sample got %0d expected 0", $time, mix_sample);
          stop_on_error("mix not silent with no voice active");
        end
      end
    end
    assert (ones >= 2047 && ones <= 2049) else begin
      $display("FAIL t=%0t pdm_out ones got %0d expected 2048", $time, ones);
      stop_on_error("pulse density off half scale");
    end
    @(posedge Clk);
  endtask

  ////////////////////
  // sigma-delta model and timeout

  always @(negedge Clk) begin : dac_model
    logic [`MIX_W-1:0] lvl;
    logic [`MIX_W:0] sum;
    if (rst_q) begin
      m_acc = '0;
      m_held = '0;
      exp_pdm = 1'b0;
    end else begin
      lvl = m_held + HALF_SCALE; // offset to unsigned
      sum = {1'b0, m_acc} + {1'b0, lvl};
      exp_pdm = sum[`MIX_W]; // carry out
      m_acc = sum[`MIX_W-1:0];
      if (mv_q) m_held = ms_q; // mix from the previous cycle
    end
    if (cmp_on) begin
      assert (pdm_out == exp_pdm) else begin
        $display("FAIL t=%0t pdm_out got %b expected %b", $time, pdm_out, exp_pdm);
        stop_on_error("modulator output differs from the model");
      end
    end
    if (mix_valid) cmp_on = 1'b1;
    if (mix_valid && mix_sample != '0 && voice_active != '0) nonzero_mix++;
    rst_q = reset;
    mv_q = mix_valid;
    ms_q = mix_sample;
  end

  always @(posedge Clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) stop_on_error("run hit the cycle limit");
  end

  ////////////////////
  // test sequence

  initial begin
    note_t n;
    logic [3:0] ch;
    Clk = 1'b0;
    reset = 1'b1;
    midi_in = 1'b1; // idle line
    rng_state = 32'd40438;
    model_active = '0;
    cycles = 0;
    nonzero_mix = 0;
    rst_q = 1'b1;
    mv_q = 1'b0;
    ms_q = '0;
    cmp_on = 1'b0;
    repeat (10) @(posedge Clk);
    reset <= 1'b0;
    @(negedge Clk);
    assert (voice_active == '0 && !mix_valid && !pdm_out && mix_sample == '0) else begin
      $display(
        "FAIL t=%0t voice_active=%b mix_valid=%b pdm_out=%b mix_sample=%0d expected 0",
        $time, voice_active, mix_valid, pdm_out, mix_sample);
      stop_on_error("outputs not cleared by reset");
    end
    @(posedge Clk);
    for (int k = 0; k < 3; k++) begin // random note on, any channel
      send_msg({4'h9, rand_chan()}, note_t'(next_rand() % 128), rand_vel());
      check_voices("note on");
    end
    release_all(1'b0); // note off in both forms
    for (int k = 0; k < NV - 1; k++) begin // fill all but the top slot
      send_msg({4'h9, rand_chan()}, fresh_note(), rand_vel());
      check_voices("fill");
    end
    n = model_note[next_rand() % (NV - 1)];
    send_msg({4'h9, rand_chan()}, n, rand_vel());
    check_voices("repeated note on"); // top slot still free here
    send_msg({4'h9, rand_chan()}, fresh_note(), rand_vel());
    check_voices("fill last slot");
    send_msg({4'h9, rand_chan()}, fresh_note(), rand_vel());
    check_voices("fifth note");
    n = fresh_note();
    send_off(n);
    check_voices("note off for an absent note");
    release_all(1'b0);
    ch = rand_chan();
    send_byte({4'h9, ch}); // running status from here
    for (int k = 0; k < 3; k++) begin
      send_pair(fresh_note(), rand_vel(), 1'b1, 1'b1);
      check_voices("running status note on");
    end
    send_pair(model_note[0], '0, 1'b1, 1'b1);
    check_voices("running status zero velocity");
    send_byte({4'hC, ch}); // program change drops running status
    send_byte({1'b0, fresh_note()}); // would start a voice under a stale status
    send_byte(8'h40);
    check_voices("data after program change");
    release_all(1'b1);
    check_silence();
    assert (nonzero_mix > 0) else stop_on_error("no sound in the mix while voices played");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/synth_pkg.sv
midi/midi_uart_rx.sv
midi/midi_parser.sv
voice/voice_alloc.sv
voice/voice_osc.sv
rtl/sigma_delta_dac.sv
rtl/synth_top.sv
verif/synth_tb.sv

// File: voice/voice_alloc.sv
`timescale 1ns/1ps
`include "synth_settings.svh"

module voice_alloc import synth_pkg::*; (
  input logic Clk,
  input logic reset,
  input logic ev_valid,
  input note_cmd_e ev_cmd,
  input note_t ev_note,
  output logic ev_ready,
  output logic [`NUM_VOICES-1:0] voice_active,
  output note_t voice_note [`NUM_VOICES]
);

  typedef enum logic [1:0] {SCAN_IDLE, SCAN_MATCH, SCAN_FREE} scan_state_e;

  localparam voice_idx_t LAST_SLOT = voice_idx_t'(`NUM_VOICES - 1);

  scan_state_e state;
  voice_idx_t idx; // slot under inspection
  note_cmd_e cur_cmd; // event being served
  note_t cur_note;
  logic hit; // slot already holds this note
  logic slot_free;
  logic at_last;

  assign ev_ready = (state == SCAN_IDLE);
  assign hit = voice_active[idx] && (voice_note[idx] == cur_note);
  assign slot_free = !voice_active[idx];
  assign at_last = (idx == LAST_SLOT);

  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= SCAN_IDLE;
      idx <= '0;
      voice_active <= '0;
    end else begin
      case (state)
        SCAN_IDLE: begin
          if (ev_valid) begin
            state <= SCAN_MATCH;
            idx <= '0;
          end
        end
        SCAN_MATCH: begin // first pass looks for the same note
          if (hit) begin
            if (cur_cmd == NOTE_OFF) begin
              voice_active[idx] <= 1'b0;
            end
            state <= SCAN_IDLE; // repeated note on keeps its slot
          end else if (!at_last) begin
            idx <= idx + 1'b1;
          end else if (cur_cmd == NOTE_ON) begin
            state <= SCAN_FREE;
            idx <= '0;
          end else begin
            state <= SCAN_IDLE; // off for an absent note
          end
        end
        SCAN_FREE: begin // second pass takes the lowest free slot
          if (slot_free) begin
            voice_active[idx] <= 1'b1;
            state <= SCAN_IDLE;
          end else if (!at_last) begin
            idx <= idx + 1'b1;
          end else begin
            state <= SCAN_IDLE; // all busy so drop it
          end
        end
        default: state <= SCAN_IDLE;
      endcase
    end
  end

  ////////////////////
  // event latch and note table

  always_ff @(posedge Clk) begin
    if (state == SCAN_IDLE && ev_valid) begin
      cur_cmd <= ev_cmd;
      cur_note <= ev_note;
    end
    if (state == SCAN_FREE && slot_free) begin
      voice_note[idx] <= cur_note;
    end
  end

endmodule

// File: voice/voice_osc.sv
`timescale 1ns/1ps
`include "synth_settings.svh"

module voice_osc import synth_pkg::*; (
  input logic Clk,
  input logic reset,
  input logic [`NUM_VOICES-1:0] voice_active,
  input note_t voice_note [`NUM_VOICES],
  output mix_t mix_sample,
  output logic mix_valid
);

  localparam int SINE_LEN = 2 ** `SINE_ADDR_W;
  localparam voice_idx_t LAST_VOICE = voice_idx_t'(`NUM_VOICES - 1);

  typedef sample_t sine_tab_t [SINE_LEN];

  // bhaskara approximation of one full sine period
  function automatic sine_tab_t build_sine();
    sine_tab_t tab;
    longint half;
    longint amp;
    longint u;
    longint p;
    longint mag;
    half = SINE_LEN / 2;
    amp = 2 ** (`SAMPLE_W - 1) - 1;
    for (int i = 0; i < SINE_LEN; i++) begin
      u = i % half; // position inside the half period
      p = u * (half - u);
      mag = (16 * amp * p + (5 * half * half - 4 * p) / 2) / (5 * half * half - 4 * p);
      tab[i] = (i < half) ? sample_t'(mag) : sample_t'(-mag); // second half negative
    end
    return tab;
  endfunction

  localparam sine_tab_t SINE_ROM = build_sine();

  phase_t phase [`NUM_VOICES]; // one accumulator per voice
  voice_idx_t vis; // voice visited this cycle
  note_t cur_note;
  logic [3:0] semi; // note mod 12
  logic [3:0] octave; // note / 12
  phase_t cur_inc;
  phase_t next_phase;
  phase_t s1_phase;
  logic s1_active;
  logic s1_last;
  sample_t s2_sample;
  logic s2_last;
  mix_t acc; // running frame sum

  assign cur_note = voice_note[vis];
  assign semi = 4'(cur_note % 7'd12);
  assign octave = 4'(cur_note / 7'd12);
  assign cur_inc = base_inc[semi] >> (4'd10 - octave);
  assign next_phase = voice_active[vis] ? phase[vis] + cur_inc : '0; // idle voice parks at 0

  ////////////////////
  // stage 1 phase update

  always_ff @(posedge Clk) begin
    phase[vis] <= next_phase;
    s1_phase <= next_phase;
  end

  ////////////////////
  // stage 2 table read and stage 3 accumulate

  always_ff @(posedge Clk) begin
    if (reset) begin
      vis <= '0;
      s1_active <= 1'b0;
      s1_last <= 1'b0;
      s2_sample <= '0;
      s2_last <= 1'b0;
      acc <= '0;
      mix_sample <= '0;
      mix_valid <= 1'b0;
    end else begin
      vis <= vis + 1'b1; // round robin
      s1_active <= voice_active[vis];
      s1_last <= (vis == LAST_VOICE);
      s2_sample <= s1_active ? SINE_ROM[s1_phase[`PHASE_W-1 -: `SINE_ADDR_W]] : '0;
      s2_last <= s1_last;
      mix_valid <= s2_last; // 3 cycles after the last visit
      if (s2_last) begin
        mix_sample <= acc + mix_t'(s2_sample); // close the frame
        acc <= '0;
      end else begin
        acc <= acc + mix_t'(s2_sample); // sign extended
      end
    end
  end

endmodule
